// ==== files.f ====
hw/ps2_pkg.sv
hw/ps2_line_sampler.sv
hw/ps2_frame_receiver.sv
hw/ps2_axil_regs.sv
hw/ps2_rx_top.sv
sim/ps2_rx_tb.sv

// ==== Bender.yml ====
package:
  name: ps2_rx

sources:
  - hw/ps2_pkg.sv
  - hw/ps2_line_sampler.sv
  - hw/ps2_frame_receiver.sv
  - hw/ps2_axil_regs.sv
  - hw/ps2_rx_top.sv
  - target: simulation
    files:
      - sim/ps2_rx_tb.sv

// ==== sim/ps2_rx_tb.sv ====
// Testbench for the PS/2 receive port: a PS/2 device model sends frames and an
// AXI4-Lite master reads the registers back against a reference model.
`timescale 1ns/1ps

module ps2_rx_tb;

    localparam int CLK_PERIOD   = 100;    // ns
    localparam int HALF_BIT     = 20;     // ACLK cycles per PS/2 clock phase.
    localparam int SEED         = 17599;
    localparam int NUM_FRAMES   = 12;     // Frames sent over all tests.
    localparam int NUM_INHIBITS = 2;
    localparam longint WATCHDOG_NS = (longint'(NUM_FRAMES) * 11 * 2 * HALF_BIT
        + longint'(NUM_INHIBITS) * ps2_pkg::INHIBIT_CYCLES + 2000) * CLK_PERIOD;

    logic ACLK = 1'b0;
    logic ARESETn, awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
    logic [15:0] awaddr_i, araddr_i;
    logic [31:0] wdata_i, rdata_o;
    logic awready_o, wready_o, bvalid_o, arready_o, rvalid_o, ps2_clock_t_o, interrupt_o;
    logic dev_clk, dev_data;  // What the device drives on its open-drain lines.
    logic ps2_clock_pin;
    int unsigned cycle = 0, parity_cycle = 0, fall_cycle = 0, rise_cycle = 0;
    int errors = 0, checks = 0, tests = 0, test_err_start = 0;
    logic clk_t_prev = 1'b1;
    logic model_full = 1'b0, model_gie = 1'b0, model_ie = 1'b0;
    logic [7:0] model_byte = 8'h00;
    logic [31:0] exp_q[$], act_q[$], cmp_exp, cmp_act;
    string name_q[$], cmp_name;

    // The host pulls the clock low through the board buffer while ps2_clock_t_o is low.
    assign ps2_clock_pin = (ps2_clock_t_o === 1'b0) ? 1'b0 : dev_clk;

    ps2_rx_top ps2_rx_top_i (
        .ACLK, .ARESETn, .awvalid_i, .awready_o, .awaddr_i, .wvalid_i, .wready_o, .wdata_i,
        .bvalid_o, .bready_i, .arvalid_i, .arready_o, .araddr_i, .rvalid_o, .rready_i,
        .rdata_o, .ps2_clock_i (ps2_clock_pin), .ps2_data_i (dev_data),
        .ps2_clock_t_o, .interrupt_o
    );

    always #(CLK_PERIOD / 2) ACLK = ~ACLK;
    always @(posedge ACLK) cycle <= cycle + 1;

    // Records when the host starts and stops inhibiting, sampled mid-cycle.
    always @(negedge ACLK) begin
        if (ARESETn && !ps2_clock_t_o && clk_t_prev) fall_cycle = cycle;
        if (ARESETn && ps2_clock_t_o && !clk_t_prev) rise_cycle = cycle;
        clk_t_prev = ps2_clock_t_o;
    end

    // Compare process. Every queued expectation is checked once per cycle.
    always @(negedge ACLK) begin
        while (exp_q.size() > 0) begin
            cmp_exp  = exp_q.pop_front();
            cmp_act  = act_q.pop_front();
            cmp_name = name_q.pop_front();
            checks++;
            if (cmp_act !== cmp_exp) begin
                $display("[FAIL] %s: expected 0x%08h, got 0x%08h", cmp_name, cmp_exp, cmp_act);
                errors++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    task automatic next_drive_slot();
        @(posedge ACLK);
        #10;  // Inputs change a little after the edge.
    endtask

    task automatic expect_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        exp_q.push_back(exp);
        act_q.push_back(act);
        name_q.push_back(name);
    endtask

    // Parity bit that makes the count of ones in byte plus parity odd.
    function automatic logic odd_parity_bit(input logic [7:0] value);
        return ($countones(value) % 2) == 0;
    endfunction

    // Reference model of one received frame. Returns whether the byte is taken.
    function automatic logic predict_frame(input logic [7:0] value, input logic parity_good,
            input logic full_now, input logic [7:0] held, input logic gie, input logic ie,
            output logic [31:0] exp_status, output logic [31:0] exp_rxdata,
            output logic exp_irq);
        logic accepted;
        logic full_next;
        accepted   = parity_good && !full_now;  // Bad parity and overrun both refuse.
        full_next  = full_now || accepted;
        exp_status = {7'b0, full_next, 24'b0};
        exp_rxdata = {accepted ? value : held, 24'b0};
        exp_irq    = gie && ie && full_next;
        return accepted;
    endfunction

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        next_drive_slot();
        awaddr_i  = addr;
        awvalid_i = 1'b1;
        while (!awready_o) next_drive_slot();
        next_drive_slot();  // AW transfer took place on this edge.
        awvalid_i = 1'b0;
        wdata_i   = data;
        wvalid_i  = 1'b1;
        checks++;
        if (!wready_o) begin
            $display("Write to 0x%04h gave no WREADY one cycle after the address", addr);
            errors++;
        end
        while (!wready_o) next_drive_slot();
        next_drive_slot();
        wvalid_i = 1'b0;
        bready_i = 1'b1;
        checks++;
        if (!bvalid_o) begin
            $display("Write to 0x%04h gave no BVALID one cycle after the data", addr);
            errors++;
        end
        while (!bvalid_o) next_drive_slot();
        next_drive_slot();
        bready_i = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
        int hold;
        hold = $urandom_range(3, 0);
        next_drive_slot();
        araddr_i  = addr;
        arvalid_i = 1'b1;
        while (!arready_o) next_drive_slot();
        next_drive_slot();
        arvalid_i = 1'b0;
        checks++;
        if (!rvalid_o) begin
            $display("Read of 0x%04h gave no RVALID one cycle after the address", addr);
            errors++;
        end
        repeat (hold) next_drive_slot();  // Back-pressure on the read data.
        rready_i = 1'b1;
        data     = rdata_o;
        next_drive_slot();
        rready_i = 1'b0;
    endtask

    // Device model: start, eight data bits LSB first, parity, stop.
    task automatic send_frame(input logic [7:0] value, input logic parity_bit);
        logic [10:0] bits;
        int i;
        bits = {1'b1, parity_bit, value, 1'b0};
        while (!ps2_clock_t_o) next_drive_slot();  // The device waits out an inhibit.
        for (i = 0; i < 11; i++) begin
            dev_data = bits[i];
            repeat (HALF_BIT) next_drive_slot();
            dev_clk = 1'b0;
            if (i == 9) parity_cycle = cycle;
            repeat (HALF_BIT) next_drive_slot();
            dev_clk = 1'b1;
        end
        dev_data = 1'b1;
        repeat (HALF_BIT) next_drive_slot();
    endtask

    task automatic receive_and_check(input logic [7:0] value, input logic parity_good);
        logic [31:0] exp_status, exp_rxdata, data;
        logic exp_irq;
        logic accepted;
        send_frame(value, parity_good ? odd_parity_bit(value) : !odd_parity_bit(value));
        accepted = predict_frame(value, parity_good, model_full, model_byte, model_gie,
                                 model_ie, exp_status, exp_rxdata, exp_irq);
        model_full = model_full || accepted;
        model_byte = exp_rxdata[31:24];
        read_reg(ps2_pkg::ADDR_STATUS, data);
        expect_word("status", exp_status, data);
        expect_word("interrupt_o", {31'b0, exp_irq}, {31'b0, interrupt_o});
    endtask

    task automatic read_rxdata_and_check();
        logic [31:0] data;
        read_reg(ps2_pkg::ADDR_RXDATA, data);
        expect_word("rxdata", {model_byte, 24'b0}, data);
        model_full = 1'b0;  // Reading the byte frees the holding register.
    endtask

    // Checks the inhibit window that follows the last parity edge.
    task automatic check_inhibit();
        while (!ps2_clock_t_o) next_drive_slot();
        next_drive_slot();
        checks++;
        if (fall_cycle <= parity_cycle || fall_cycle - parity_cycle > 20) begin
            $display("The clock line was not pulled low within 20 cycles of the parity edge");
            errors++;
        end
        checks++;
        if (rise_cycle - fall_cycle < ps2_pkg::INHIBIT_CYCLES ||
            rise_cycle - fall_cycle > ps2_pkg::INHIBIT_CYCLES + 2) begin
            $display("The clock line was held low for %0d cycles", rise_cycle - fall_cycle);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        @(negedge ACLK);
        #1;  // Let the compare process drain its queue first.
        tests++;
        if (errors == test_err_start) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - test_err_start);
        test_err_start = errors;
    endtask

    initial begin
        logic [31:0] data;
        int g, e, n;
        void'($urandom(SEED));
        {ARESETn, awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i} = '0;
        {awaddr_i, araddr_i, wdata_i} = '0;
        dev_clk  = 1'b1;
        dev_data = 1'b1;
        repeat (4) @(posedge ACLK);
        #10;
        ARESETn = 1'b1;

        expect_word("awready_o", 32'h1, {31'b0, awready_o});
        expect_word("wready_o", 32'h0, {31'b0, wready_o});
        expect_word("arready_o", 32'h1, {31'b0, arready_o});
        expect_word("bvalid_o", 32'h0, {31'b0, bvalid_o});
        expect_word("rvalid_o", 32'h0, {31'b0, rvalid_o});
        expect_word("interrupt_o", 32'h0, {31'b0, interrupt_o});
        expect_word("ps2_clock_t_o", 32'h1, {31'b0, ps2_clock_t_o});
        read_reg(ps2_pkg::ADDR_STATUS, data);
        expect_word("status", 32'h0, data);
        read_reg(ps2_pkg::ADDR_ISR, data);
        expect_word("isr", 32'h0, data);
        read_reg(ps2_pkg::ADDR_GIE, data);
        expect_word("gie", 32'h0, data);
        read_reg(ps2_pkg::ADDR_IER, data);
        expect_word("ier", 32'h0, data);
        end_test("reset");

        for (n = 0; n < 8; n++) begin
            receive_and_check(8'($urandom_range(255, 0)), 1'b1);
            read_rxdata_and_check();
            read_reg(ps2_pkg::ADDR_STATUS, data);
            expect_word("status", 32'h0, data);  // Full flag cleared by the data read.
        end
        end_test("good frames");

        receive_and_check(8'($urandom_range(255, 0)), 1'b0);
        check_inhibit();
        end_test("parity error");

        receive_and_check(8'h5A, 1'b1);
        receive_and_check(8'hC3, 1'b1);  // Arrives while the first byte is unread.
        check_inhibit();
        read_rxdata_and_check();
        end_test("overrun");

        write_reg(ps2_pkg::ADDR_GIE, 32'h0000_0080);
        model_gie = 1'b1;
        read_reg(ps2_pkg::ADDR_GIE, data);
        expect_word("gie", 32'h0000_0080, data);
        write_reg(ps2_pkg::ADDR_IER, 32'h2000_0000);
        model_ie = 1'b1;
        read_reg(ps2_pkg::ADDR_IER, data);
        expect_word("ier", 32'h2000_0000, data);
        read_reg(16'h0000, data);
        expect_word("unmapped 0x0000", 32'h0, data);
        read_reg(16'h003C, data);
        expect_word("unmapped 0x003C", 32'h0, data);
        receive_and_check(8'h81, 1'b1);
        read_reg(ps2_pkg::ADDR_ISR, data);
        expect_word("isr", 32'h2000_0000, data);
        for (g = 0; g < 2; g++) begin
            for (e = 0; e < 2; e++) begin
                write_reg(ps2_pkg::ADDR_GIE, 32'(g) << 7);
                write_reg(ps2_pkg::ADDR_IER, 32'(e) << 29);
                model_gie = g[0];
                model_ie  = e[0];
                next_drive_slot();
                expect_word("interrupt_o", {31'b0, model_gie & model_ie & model_full},
                            {31'b0, interrupt_o});
            end
        end
        read_rxdata_and_check();
        next_drive_slot();
        expect_word("interrupt_o", 32'h0, {31'b0, interrupt_o});
        end_test("registers and interrupt");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== hw/ps2_rx_top.sv ====
// PS/2 receive port with an AXI4-Lite register slave. The board buffer ties
// the clock pin output to 0, so ps2_clock_t_o is an active-low drive enable.
`timescale 1ns/1ps

module ps2_rx_top (
    input  logic                        ACLK,
    input  logic                        ARESETn,
    input  logic                        awvalid_i,
    output logic                        awready_o,
    input  logic [ps2_pkg::ADDR_W-1:0]  awaddr_i,
    input  logic                        wvalid_i,
    output logic                        wready_o,
    input  logic [ps2_pkg::DATA_W-1:0]  wdata_i,
    output logic                        bvalid_o,
    input  logic                        bready_i,
    input  logic                        arvalid_i,
    output logic                        arready_o,
    input  logic [ps2_pkg::ADDR_W-1:0]  araddr_i,
    output logic                        rvalid_o,
    input  logic                        rready_i,
    output logic [ps2_pkg::DATA_W-1:0]  rdata_o,
    input  logic                        ps2_clock_i,
    input  logic                        ps2_data_i,
    output logic                        ps2_clock_t_o,
    output logic                        interrupt_o
);

    logic                       clock_fall;     // Sampler to receiver.
    logic                       data_bit;
    logic [ps2_pkg::BYTE_W-1:0] rx_byte;        // Receiver to register slave.
    logic                       rx_byte_valid;
    logic                       rx_full;        // Back from the register slave.

    ps2_line_sampler u_sampler (
        .ACLK, .ARESETn, .ps2_clock_i, .ps2_data_i,
        .clock_fall_o (clock_fall),
        .data_bit_o   (data_bit)
    );

    ps2_frame_receiver u_receiver (
        .ACLK, .ARESETn,
        .clock_fall_i (clock_fall), .data_bit_i (data_bit), .rx_full_i (rx_full),
        .rx_byte_o (rx_byte), .rx_byte_valid_o (rx_byte_valid), .ps2_clock_t_o
    );

    ps2_axil_regs u_regs (
        .ACLK, .ARESETn,
        .awvalid_i, .awready_o, .awaddr_i, .wvalid_i, .wready_o, .wdata_i,
        .bvalid_o, .bready_i, .arvalid_i, .arready_o, .araddr_i,
        .rvalid_o, .rready_i, .rdata_o,
        .rx_byte_i (rx_byte), .rx_byte_valid_i (rx_byte_valid),
        .rx_full_o (rx_full), .interrupt_o
    );

endmodule

// ==== hw/ps2_axil_regs.sv ====
// Third stage: AXI4-Lite register slave. Holds the received byte and its full
// flag, the interrupt enables, and drives the level interrupt.
`timescale 1ns/1ps

module ps2_axil_regs (
    input  logic                        ACLK,
    input  logic                        ARESETn,
    // Write address channel.
    input  logic                        awvalid_i,
    output logic                        awready_o,
    input  logic [ps2_pkg::ADDR_W-1:0]  awaddr_i,
    // Write data channel.
    input  logic                        wvalid_i,
    output logic                        wready_o,
    input  logic [ps2_pkg::DATA_W-1:0]  wdata_i,
    // Write response channel.
    output logic                        bvalid_o,
    input  logic                        bready_i,
    // Read address channel.
    input  logic                        arvalid_i,
    output logic                        arready_o,
    input  logic [ps2_pkg::ADDR_W-1:0]  araddr_i,
    // Read data channel.
    output logic                        rvalid_o,
    input  logic                        rready_i,
    output logic [ps2_pkg::DATA_W-1:0]  rdata_o,
    // From and to the frame receiver.
    input  logic [ps2_pkg::BYTE_W-1:0]  rx_byte_i,
    input  logic                        rx_byte_valid_i,
    output logic                        rx_full_o,
    output logic                        interrupt_o   // Level, active high.
);

    ps2_pkg::wr_state_e             wr_state;
    ps2_pkg::rd_state_e             rd_state;
    logic [ps2_pkg::ADDR_W-1:0]     wr_addr;      // Latched on the AW transfer.
    logic [ps2_pkg::BYTE_W-1:0]     rx_data;      // Last accepted byte.
    logic [ps2_pkg::DATA_W-1:0]     rd_word;      // Read mux output.
    logic                           rx_full;
    logic                           gie;          // Global interrupt enable.
    logic                           rx_full_ie;   // Receive-full interrupt enable.
    logic                           aw_xfer;
    logic                           w_xfer;
    logic                           ar_xfer;

    assign awready_o = (wr_state == ps2_pkg::WR_ADDR);
    assign wready_o  = (wr_state == ps2_pkg::WR_DATA);
    assign bvalid_o  = (wr_state == ps2_pkg::WR_RESP);
    assign arready_o = (rd_state == ps2_pkg::RD_ADDR);
    assign rvalid_o  = (rd_state == ps2_pkg::RD_DATA);

    assign aw_xfer = awvalid_i && awready_o;
    assign w_xfer  = wvalid_i && wready_o;
    assign ar_xfer = arvalid_i && arready_o;

    // Write channel: address first, then data, then the response.
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            wr_state   <= ps2_pkg::WR_ADDR;
            gie        <= 1'b0;
            rx_full_ie <= 1'b0;
        end else begin
            case (wr_state)
                ps2_pkg::WR_ADDR: if (aw_xfer) wr_state <= ps2_pkg::WR_DATA;
                ps2_pkg::WR_DATA: begin
                    if (w_xfer) begin
                        wr_state <= ps2_pkg::WR_RESP;
                        // Only the enable bits are writable. ISR and the rest ignore writes.
                        case (wr_addr)
                            ps2_pkg::ADDR_GIE: gie        <= wdata_i[ps2_pkg::BIT_GIE];
                            ps2_pkg::ADDR_IER: rx_full_ie <= wdata_i[ps2_pkg::BIT_RX_FULL];
                            default: ;
                        endcase
                    end
                end
                ps2_pkg::WR_RESP: if (bready_i) wr_state <= ps2_pkg::WR_ADDR;
                default: wr_state <= ps2_pkg::WR_ADDR;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (aw_xfer) wr_addr <= awaddr_i;  // Used on the following W transfer.
    end

    // Register map as seen by a read. Unmapped offsets return zero.
    always_comb begin
        rd_word = '0;
        case (araddr_i)
            ps2_pkg::ADDR_STATUS: rd_word[ps2_pkg::BIT_STATUS_RX_FULL] = rx_full;
            ps2_pkg::ADDR_RXDATA: rd_word[ps2_pkg::RXDATA_LSB +: ps2_pkg::BYTE_W] = rx_data;
            ps2_pkg::ADDR_GIE:    rd_word[ps2_pkg::BIT_GIE] = gie;
            ps2_pkg::ADDR_ISR:    rd_word[ps2_pkg::BIT_RX_FULL] = rx_full;
            ps2_pkg::ADDR_IER:    rd_word[ps2_pkg::BIT_RX_FULL] = rx_full_ie;
            default: ;
        endcase
    end

    // Read channel. Data is captured on the AR transfer and held until RREADY.
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            rd_state <= ps2_pkg::RD_ADDR;
        end else begin
            case (rd_state)
                ps2_pkg::RD_ADDR: if (ar_xfer) rd_state <= ps2_pkg::RD_DATA;
                ps2_pkg::RD_DATA: if (rready_i) rd_state <= ps2_pkg::RD_ADDR;
                default: rd_state <= ps2_pkg::RD_ADDR;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (ar_xfer) rdata_o <= rd_word;
    end

    // Holding byte. The receiver has already decided the byte is wanted.
    always_ff @(posedge ACLK) begin
        if (rx_byte_valid_i) rx_data <= rx_byte_i;
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            rx_full <= 1'b0;
        end else if (rx_byte_valid_i) begin
            rx_full <= 1'b1;  // A new byte wins over a clearing read.
        end else if (ar_xfer && (araddr_i == ps2_pkg::ADDR_RXDATA)) begin
            rx_full <= 1'b0;
        end
    end

    assign rx_full_o   = rx_full;
    assign interrupt_o = gie && rx_full_ie && rx_full;

    // The write response waits for the master.
    a_bvalid_hold: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        bvalid_o && !bready_i |=> bvalid_o
    );

    // Read data waits for the master and does not change meanwhile.
    a_rvalid_hold: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o)
    );

endmodule

// ==== hw/ps2_frame_receiver.sv ====
// Second stage: assembles start, data, parity and stop bits into a byte and
// holds the PS/2 clock low to force a resend when the byte cannot be taken.
`timescale 1ns/1ps

module ps2_frame_receiver (
    input  logic                        ACLK,
    input  logic                        ARESETn,
    input  logic                        clock_fall_i,     // Falling edge strobe.
    input  logic                        data_bit_i,       // Synchronous data level.
    input  logic                        rx_full_i,        // Holding byte not yet read.
    output logic [ps2_pkg::BYTE_W-1:0]  rx_byte_o,
    output logic                        rx_byte_valid_o,  // One-cycle load strobe.
    output logic                        ps2_clock_t_o     // Low drives the clock pin low.
);

    ps2_pkg::rx_state_e                     state;
    logic [$clog2(ps2_pkg::BYTE_W)-1:0]     bit_cnt;      // Data bits taken so far.
    logic [ps2_pkg::BYTE_W-1:0]             shift_reg;    // Filled from the top, LSB first.
    logic [ps2_pkg::INHIBIT_W-1:0]          inhibit_cnt;  // Nonzero while inhibiting.
    logic                                   parity_ok;
    logic                                   accept;
    logic                                   reject;

    // Odd parity: the parity bit makes the total count of ones odd.
    assign parity_ok = (data_bit_i == ~^shift_reg);

    // Both decisions are made on the parity edge only.
    assign accept = (state == ps2_pkg::RX_PARITY) && clock_fall_i && parity_ok && !rx_full_i;
    assign reject = (state == ps2_pkg::RX_PARITY) && clock_fall_i && !accept;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state   <= ps2_pkg::RX_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                ps2_pkg::RX_IDLE: begin
                    // A real start bit cannot show up while we hold the clock low.
                    if (clock_fall_i && !data_bit_i && (inhibit_cnt == '0)) begin
                        state   <= ps2_pkg::RX_DATA;
                        bit_cnt <= '0;
                    end
                end
                ps2_pkg::RX_DATA: begin
                    if (clock_fall_i) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'(ps2_pkg::BYTE_W - 1)) begin
                            state <= ps2_pkg::RX_PARITY;  // Eighth bit just arrived.
                        end
                    end
                end
                ps2_pkg::RX_PARITY: begin
                    if (accept) begin
                        state <= ps2_pkg::RX_STOP;
                    end else if (reject) begin
                        state <= ps2_pkg::RX_IDLE;  // The device will start over.
                    end
                end
                ps2_pkg::RX_STOP: begin
                    if (clock_fall_i) begin
                        state <= ps2_pkg::RX_IDLE;  // Stop bit level is not checked.
                    end
                end
                default: state <= ps2_pkg::RX_IDLE;
            endcase
        end
    end

    // Data shift register carries payload only.
    always_ff @(posedge ACLK) begin
        if ((state == ps2_pkg::RX_DATA) && clock_fall_i) begin
            shift_reg <= {data_bit_i, shift_reg[ps2_pkg::BYTE_W-1:1]};
        end
    end

    // Inhibit counter. Parity errors and overruns both reload it.
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            inhibit_cnt <= '0;
        end else if (reject) begin
            inhibit_cnt <= ps2_pkg::INHIBIT_CYCLES;
        end else if (inhibit_cnt != '0) begin
            inhibit_cnt <= inhibit_cnt - 1'b1;
        end
    end

    assign rx_byte_o       = shift_reg;            // Complete while in the parity state.
    assign rx_byte_valid_o = accept;
    assign ps2_clock_t_o   = (inhibit_cnt == '0);  // Release the line when the count runs out.

    // No frame may start while the bus is being inhibited.
    a_no_start_while_inhibit: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        (state == ps2_pkg::RX_IDLE) && (inhibit_cnt != '0) |=> state != ps2_pkg::RX_DATA
    );

    // One frame yields at most one load strobe.
    a_valid_single_cycle: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        rx_byte_valid_o |=> !rx_byte_valid_o
    );

endmodule

// ==== hw/ps2_line_sampler.sv ====
// First stage of the PS/2 receiver: brings the pins into the ACLK domain
// and flags each falling edge of the device clock with a one-cycle strobe.
`timescale 1ns/1ps

module ps2_line_sampler (
    input  logic ACLK,
    input  logic ARESETn,
    input  logic ps2_clock_i,   // Asynchronous PS/2 clock pin.
    input  logic ps2_data_i,    // Asynchronous PS/2 data pin.
    output logic clock_fall_o,  // High for one cycle per falling clock edge.
    output logic data_bit_o     // Data pin level, synchronous to ACLK.
);

    logic [ps2_pkg::SYNC_DEPTH-1:0] clock_dly;  // Tap 0 is the newest sample.
    logic [1:0]                     data_dly;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            // An idle bus sits high, so preset the taps and avoid a false edge.
            clock_dly    <= '1;
            data_dly     <= '1;
            clock_fall_o <= 1'b0;
        end else begin
            clock_dly <= {clock_dly[ps2_pkg::SYNC_DEPTH-2:0], ps2_clock_i};
            data_dly  <= {data_dly[0], ps2_data_i};  // Two flops are enough for data.
            // Older tap still high while the next one is already low.
            clock_fall_o <= clock_dly[ps2_pkg::SYNC_DEPTH-1] &
                            ~clock_dly[ps2_pkg::SYNC_DEPTH-2];
        end
    end

    // The device changes data while the clock is high, long before the edge.
    assign data_bit_o = data_dly[1];

endmodule

// ==== hw/ps2_pkg.sv ====
// Shared widths, register map and state encodings for the PS/2 receive port.
// The RTL modules refer to these through scoped names.
package ps2_pkg;

    // Bus and data widths.
    localparam int unsigned ADDR_W = 16;     // AXI4-Lite address width.
    localparam int unsigned DATA_W = 32;     // AXI4-Lite data width.
    localparam int unsigned BYTE_W = 8;      // One PS/2 data byte.

    // The clock line passes through this many flops before edge detection.
    localparam int unsigned SYNC_DEPTH = 4;

    // Inhibit timing. The counter is loaded with all ones on a rejected frame.
    localparam int unsigned INHIBIT_W = 14;
    localparam logic [INHIBIT_W-1:0] INHIBIT_CYCLES = 14'd16383;

    // Register offsets, kept at the positions software already expects.
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 16'h0004;  // Status, read only.
    localparam logic [ADDR_W-1:0] ADDR_RXDATA = 16'h0008;  // Received byte, read clears full.
    localparam logic [ADDR_W-1:0] ADDR_GIE    = 16'h002C;  // Global interrupt enable.
    localparam logic [ADDR_W-1:0] ADDR_ISR    = 16'h0030;  // Interrupt status.
    localparam logic [ADDR_W-1:0] ADDR_IER    = 16'h0038;  // Interrupt enable.

    // Bit positions inside the 32-bit registers (big-endian layout).
    localparam int unsigned BIT_RX_FULL        = 29;  // In ISR and IER.
    localparam int unsigned BIT_STATUS_RX_FULL = 24;  // The status register uses a lower bit.
    localparam int unsigned BIT_GIE            = 7;
    localparam int unsigned RXDATA_LSB         = 24;  // Byte sits in bits 31:24.

    // Frame receiver states. The eight data bits share one state and a counter.
    typedef enum logic [1:0] {
        RX_IDLE,    // Waiting for a start bit.
        RX_DATA,    // Shifting in the eight data bits.
        RX_PARITY,  // Waiting for the parity bit.
        RX_STOP     // Byte taken, waiting for the stop bit.
    } rx_state_e;

    // Write channel states.
    typedef enum logic [1:0] {
        WR_ADDR,    // Waiting for an address on AW.
        WR_DATA,    // Waiting for data on W.
        WR_RESP     // Holding the response until BREADY.
    } wr_state_e;

    // Read channel states.
    typedef enum logic [0:0] {
        RD_ADDR,    // Waiting for an address on AR.
        RD_DATA     // Holding RDATA until RREADY.
    } rd_state_e;

endpackage
